// File: design/isa_pkg.sv
/*
 * RV32I integer ALU subset
 * opcodes, function codes and ALU operation encodings,
 * plus the R-type / I-type views of one instruction word
 */

package isa_pkg;

	// data word width
	localparam int xlen = 32;

	typedef logic [4:0] reg_idx_t;

	//////////////////////////////
	// ALU operations
	//////////////////////////////

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// accepted major opcodes
	localparam logic [6:0] opcode_op     = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;

	// funct3 groups, shared by OP and OP-IMM
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7 values, also the upper immediate of shift-immediates
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	//////////////////////////////
	// instruction layouts
	//////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} instr_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} instr_i_t;

	// same 32 bits, two decodings
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

// File: design/bus_map_pkg.sv
/*
 * APB register map of the ALU core
 * bus widths, instruction port, status word and register window
 */

package bus_map_pkg;

	localparam int apb_addr_w = 12;
	localparam int apb_data_w = 32;

	// write-only instruction port
	localparam logic [apb_addr_w-1:0] addr_instr = 12'h000;

	// status: count in 7:0, sticky illegal flag in bit 8
	localparam logic [apb_addr_w-1:0] addr_status = 12'h004;

	// x[i] read at base + 4*i
	localparam logic [apb_addr_w-1:0] addr_reg_base = 12'h080;

	// committed instruction counter, wraps
	localparam int commit_cnt_w = 8;

endpackage

// File: design/instr_decode.sv
/*
 * Instruction decode stage
 * takes instruction words from APB writes, splits R and I formats,
 * maps funct3/funct7 to an ALU op and flags illegal words
 */

`timescale 1ns/1ps

module instr_decode (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [bus_map_pkg::apb_addr_w-1:0] paddr,
	input  logic [bus_map_pkg::apb_data_w-1:0] pwdata,
	output logic                               pslverr,
	output logic                               illegal_seen,
	output logic                               d_valid,
	output isa_pkg::alu_op_e                   d_op,
	output isa_pkg::reg_idx_t                  d_rs1,
	output isa_pkg::reg_idx_t                  d_rs2,
	output isa_pkg::reg_idx_t                  d_rd,
	output logic                               d_use_imm,
	output logic [isa_pkg::xlen-1:0]           d_imm
);
	import isa_pkg::*;
	import bus_map_pkg::*;

	instr_u          word;
	logic            accept;
	logic            is_op;
	logic            is_op_imm;
	logic [6:0]      imm_hi;
	logic            shift_alt;
	logic            r_legal;
	logic            i_legal;
	logic            legal;
	logic            illegal;
	alu_op_e         dec_op;
	logic [xlen-1:0] imm_sext;

	// write access phase to the instruction port
	assign accept = psel & penable & pwrite & (paddr == addr_instr);

	assign word      = pwdata;
	assign is_op     = (word.r.opcode == opcode_op);
	assign is_op_imm = (word.i.opcode == opcode_op_imm);

	// upper immediate, only meaningful for shift-immediates
	assign imm_hi   = word.i.imm12[11:5];
	assign imm_sext = {{(xlen-12){word.i.imm12[11]}}, word.i.imm12};

	// sra when the upper seven bits hold the alt code
	assign shift_alt = (word.r.funct7 == f7_alt);

	//////////////////////////////
	// legality
	//////////////////////////////

	// R-type: funct7 zero, or alt form for sub / sra only
	assign r_legal = (word.r.funct7 == f7_base) ||
		((word.r.funct7 == f7_alt) &&
		((word.r.funct3 == f3_add_sub) || (word.r.funct3 == f3_srl_sra)));

	// I-type: only the shifts restrict the upper immediate
	always_comb begin
		case (word.i.funct3)
			f3_sll:     i_legal = (imm_hi == f7_base);
			f3_srl_sra: i_legal = (imm_hi == f7_base) || (imm_hi == f7_alt);
			default:    i_legal = 1'b1;
		endcase
	end

	// bad opcode also lands here
	assign legal   = (is_op & r_legal) | (is_op_imm & i_legal);
	assign illegal = accept & ~legal;

	// error in the same access phase, flag pulse to the result stage
	assign pslverr      = illegal;
	assign illegal_seen = illegal;

	//////////////////////////////
	// op mapping
	//////////////////////////////

	always_comb begin
		case (word.r.funct3)
			// no subi, so alt only counts for R-type
			f3_add_sub: dec_op = (is_op && word.r.funct7 == f7_alt) ? alu_sub : alu_add;
			f3_sll:     dec_op = alu_sll;
			f3_slt:     dec_op = alu_slt;
			f3_sltu:    dec_op = alu_sltu;
			f3_xor:     dec_op = alu_xor;
			f3_srl_sra: dec_op = shift_alt ? alu_sra : alu_srl;
			f3_or:      dec_op = alu_or;
			default:    dec_op = alu_and;
		endcase
	end

	//////////////////////////////
	// decode stage register
	//////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
		end else begin
			// one-cycle valid per accepted legal word
			d_valid <= accept & legal;
		end
	end

	// payload, loaded only with a legal word
	always_ff @(posedge clock) begin
		if (accept && legal) begin
			d_op      <= dec_op;
			d_rs1     <= word.r.rs1;
			d_rs2     <= word.r.rs2;
			d_rd      <= word.r.rd;
			d_use_imm <= is_op_imm;
			d_imm     <= imm_sext;
		end
	end

endmodule

// File: design/alu_execute.sv
/*
 * Execute stage
 * reads operands from the register file, bypasses its own
 * last result, computes the ALU op and registers the result
 */

`timescale 1ns/1ps

module alu_execute (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     d_valid,
	input  isa_pkg::alu_op_e         d_op,
	input  isa_pkg::reg_idx_t        d_rs1,
	input  isa_pkg::reg_idx_t        d_rs2,
	input  isa_pkg::reg_idx_t        d_rd,
	input  logic                     d_use_imm,
	input  logic [isa_pkg::xlen-1:0] d_imm,
	input  logic [isa_pkg::xlen-1:0] rs1_data,
	input  logic [isa_pkg::xlen-1:0] rs2_data,
	output isa_pkg::reg_idx_t        rs1_idx,
	output isa_pkg::reg_idx_t        rs2_idx,
	output logic                     x_valid,
	output isa_pkg::reg_idx_t        x_rd,
	output logic [isa_pkg::xlen-1:0] x_result
);
	import isa_pkg::*;

	logic            byp_a;
	logic            byp_b;
	logic [xlen-1:0] op_a;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;
	logic [xlen-1:0] alu_out;

	// register file read ports
	assign rs1_idx = d_rs1;
	assign rs2_idx = d_rs2;

	//////////////////////////////
	// operand select
	//////////////////////////////

	// last result not yet in the register file
	// x0 results are never written, so never forwarded
	assign byp_a = x_valid && (x_rd != '0) && (x_rd == d_rs1);
	assign byp_b = x_valid && (x_rd != '0) && (x_rd == d_rs2);

	assign op_a    = byp_a ? x_result : rs1_data;
	assign rs2_val = byp_b ? x_result : rs2_data;

	// immediate replaces rs2 for OP-IMM
	assign op_b = d_use_imm ? d_imm : rs2_val;

	// shifts use low 5 bits only
	assign shamt = op_b[4:0];

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		case (d_op)
			alu_add:  alu_out = op_a + op_b;
			alu_sub:  alu_out = op_a - op_b;
			alu_sll:  alu_out = op_a << shamt;
			alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_xor:  alu_out = op_a ^ op_b;
			alu_srl:  alu_out = op_a >> shamt;
			// arithmetic, sign bit fills
			alu_sra:  alu_out = $signed(op_a) >>> shamt;
			alu_or:   alu_out = op_a | op_b;
			alu_and:  alu_out = op_a & op_b;
			default:  alu_out = '0;
		endcase
	end

	//////////////////////////////
	// execute stage register
	//////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			x_valid <= 1'b0;
		end else begin
			x_valid <= d_valid;
		end
	end

	// result and destination follow the valid bit
	always_ff @(posedge clock) begin
		if (d_valid) begin
			x_rd     <= d_rd;
			x_result <= alu_out;
		end
	end

endmodule

// File: design/result_regfile.sv
/*
 * Result stage and register file
 * 32 x xlen registers with x0 tied to zero, commit counter,
 * sticky illegal flag and the APB read mux
 */

`timescale 1ns/1ps

module result_regfile (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic                               x_valid,
	input  isa_pkg::reg_idx_t                  x_rd,
	input  logic [isa_pkg::xlen-1:0]           x_result,
	input  logic                               illegal_seen,
	input  isa_pkg::reg_idx_t                  rs1_idx,
	input  isa_pkg::reg_idx_t                  rs2_idx,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [bus_map_pkg::apb_addr_w-1:0] paddr,
	output logic [isa_pkg::xlen-1:0]           rs1_data,
	output logic [isa_pkg::xlen-1:0]           rs2_data,
	output logic [bus_map_pkg::apb_data_w-1:0] prdata
);
	import isa_pkg::*;
	import bus_map_pkg::*;

	// window index sits in paddr above the byte offset
	localparam int win_lsb = 2 + $bits(reg_idx_t);

	// x0 has no storage
	logic [xlen-1:0]         regs [1:31];
	logic [commit_cnt_w-1:0] commit_cnt;
	logic                    illegal_flag;
	logic [apb_data_w-1:0]   status_word;
	logic                    rd_access;
	logic                    win_hit;
	reg_idx_t                win_idx;

	//////////////////////////////
	// commit
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (x_valid && x_rd != '0) begin
			regs[x_rd] <= x_result;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			commit_cnt   <= '0;
			illegal_flag <= 1'b0;
		end else begin
			// wraps, x0 writes still count
			if (x_valid) begin
				commit_cnt <= commit_cnt + 1'b1;
			end
			if (illegal_seen) begin
				illegal_flag <= 1'b1;
			end
		end
	end

	// operand read ports, x0 reads zero
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	//////////////////////////////
	// APB read
	//////////////////////////////

	always_comb begin
		status_word                   = '0;
		status_word[commit_cnt_w-1:0] = commit_cnt;
		status_word[commit_cnt_w]     = illegal_flag;
	end

	assign rd_access = psel & penable & ~pwrite;

	// word-aligned hit in the register window
	assign win_hit = (paddr[apb_addr_w-1:win_lsb] == addr_reg_base[apb_addr_w-1:win_lsb]) &&
		(paddr[1:0] == 2'b00);
	assign win_idx = paddr[win_lsb-1:2];

	// unmapped reads return zero
	always_comb begin
		prdata = '0;
		if (rd_access) begin
			if (paddr == addr_status) begin
				prdata = status_word;
			end else if (win_hit && win_idx != '0) begin
				prdata = regs[win_idx];
			end
		end
	end

endmodule

// File: design/alu_core.sv
/*
 * ALU core top level
 * instructions enter as APB writes, then pass through
 * decode, execute and the result / register file stage
 * APB reads return registers or the status word
 */

`timescale 1ns/1ps

module alu_core (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [bus_map_pkg::apb_addr_w-1:0] paddr,
	input  logic [bus_map_pkg::apb_data_w-1:0] pwdata,
	output logic [bus_map_pkg::apb_data_w-1:0] prdata,
	output logic                               pready,
	output logic                               pslverr
);
	import isa_pkg::*;

	// decode -> execute
	logic            d_valid;
	alu_op_e         d_op;
	reg_idx_t        d_rs1;
	reg_idx_t        d_rs2;
	reg_idx_t        d_rd;
	logic            d_use_imm;
	logic [xlen-1:0] d_imm;

	// execute -> result
	logic            x_valid;
	reg_idx_t        x_rd;
	logic [xlen-1:0] x_result;

	// operand read ports
	reg_idx_t        rs1_idx;
	reg_idx_t        rs2_idx;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	// decode -> result
	logic            illegal_seen;

	// no wait states
	assign pready = 1'b1;

	//////////////////////////////
	// stages
	//////////////////////////////

	instr_decode u_decode (
		.clock        (clock),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.pslverr      (pslverr),
		.illegal_seen (illegal_seen),
		.d_valid      (d_valid),
		.d_op         (d_op),
		.d_rs1        (d_rs1),
		.d_rs2        (d_rs2),
		.d_rd         (d_rd),
		.d_use_imm    (d_use_imm),
		.d_imm        (d_imm)
	);

	alu_execute u_execute (
		.clock     (clock),
		.rst_n     (rst_n),
		.d_valid   (d_valid),
		.d_op      (d_op),
		.d_rs1     (d_rs1),
		.d_rs2     (d_rs2),
		.d_rd      (d_rd),
		.d_use_imm (d_use_imm),
		.d_imm     (d_imm),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.rs1_idx   (rs1_idx),
		.rs2_idx   (rs2_idx),
		.x_valid   (x_valid),
		.x_rd      (x_rd),
		.x_result  (x_result)
	);

	result_regfile u_result (
		.clock        (clock),
		.rst_n        (rst_n),
		.x_valid      (x_valid),
		.x_rd         (x_rd),
		.x_result     (x_result),
		.illegal_seen (illegal_seen),
		.rs1_idx      (rs1_idx),
		.rs2_idx      (rs2_idx),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.prdata       (prdata)
	);

endmodule

// File: tests/tb_apb_tasks.svh
/*
 * APB driver tasks, reference model and directed tests
 * for the ALU core testbench, included in the top module
 */

`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

//////////////////////////////
// reference model
//////////////////////////////

logic [31:0] model_regs [0:31];
logic [7:0]  model_cnt;
logic        model_flag;

// RV32I integer rules, alt picks sub / sra
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0: begin
			if (alt) begin
				return a - b;
			end
			return a + b;
		end
		3'd1: return a << b[4:0];
		3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3: return (a < b) ? 32'd1 : 32'd0;
		3'd4: return a ^ b;
		3'd5: begin
			// sign bit fills for sra
			if (alt) begin
				return $signed(a) >>> b[4:0];
			end
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic [11:0] rand_imm();
	return 12'($random(seed));
endfunction

//////////////////////////////
// APB driver
//////////////////////////////

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
		input int idle, output logic err);
	@(negedge clock);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = 1'b1;
	paddr   = addr;
	pwdata  = data;
	@(negedge clock);
	penable = 1'b1;
	// pslverr settles well before the rising edge
	#(clk_period / 4);
	err = pslverr;
	@(posedge clock);
	repeat (idle) begin
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	end
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
	@(negedge clock);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = 1'b0;
	paddr   = addr;
	@(negedge clock);
	penable = 1'b1;
	#(clk_period / 4);
	data = prdata;
	@(negedge clock);
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic bus_idle(input int cycles);
	repeat (cycles) begin
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	end
endtask

//////////////////////////////
// instruction issue and checks
//////////////////////////////

task automatic issue_imm(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
		input logic [11:0] imm, input int idle);
	instr_u w;
	logic   err;
	logic   alt;
	w          = '0;
	w.i.imm12  = imm;
	w.i.rs1    = rs1;
	w.i.funct3 = f3;
	w.i.rd     = rd;
	w.i.opcode = opcode_op_imm;
	// srai carries 0100000 above the shift amount
	alt = (f3 == f3_srl_sra) && imm[10];
	apb_write(addr_instr, w, idle, err);
	assert (err === 1'b0)
		else abort_run($sformatf("mismatch pslverr: expected %h, got %h", 1'b0, err));
	if (rd != '0) begin
		model_regs[rd] = ref_alu(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm});
	end
	model_cnt = model_cnt + 8'd1;
endtask

task automatic issue_reg(input logic [2:0] f3, input logic alt, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2, input int idle);
	instr_u w;
	logic   err;
	w          = '0;
	w.r.funct7 = alt ? f7_alt : f7_base;
	w.r.rs2    = rs2;
	w.r.rs1    = rs1;
	w.r.funct3 = f3;
	w.r.rd     = rd;
	w.r.opcode = opcode_op;
	apb_write(addr_instr, w, idle, err);
	assert (err === 1'b0)
		else abort_run($sformatf("mismatch pslverr: expected %h, got %h", 1'b0, err));
	if (rd != '0) begin
		model_regs[rd] = ref_alu(f3, alt, model_regs[rs1], model_regs[rs2]);
	end
	model_cnt = model_cnt + 8'd1;
endtask

// dropped by the core, sets the sticky flag
task automatic issue_bad(input instr_u w);
	logic err;
	apb_write(addr_instr, w, 2, err);
	assert (err === 1'b1)
		else abort_run($sformatf("mismatch pslverr: expected %h, got %h", 1'b1, err));
	model_flag = 1'b1;
endtask

// 32-bit constant from addi, slli and ori in 11/11/10 bit chunks
task automatic load_value(input reg_idx_t rd, input logic [31:0] v);
	issue_imm(f3_add_sub, rd, 5'd0, {1'b0, v[31:21]}, 2);
	issue_imm(f3_sll, rd, rd, 12'd11, 2);
	issue_imm(f3_or, rd, rd, {1'b0, v[20:10]}, 2);
	issue_imm(f3_sll, rd, rd, 12'd10, 2);
	issue_imm(f3_or, rd, rd, {2'b00, v[9:0]}, 2);
endtask

task automatic check_reg(input reg_idx_t idx);
	logic [31:0] data;
	apb_read(addr_reg_base + {5'b0, idx, 2'b00}, data);
	assert (data === model_regs[idx])
		else abort_run($sformatf("mismatch prdata x%0d: expected %h, got %h",
			idx, model_regs[idx], data));
endtask

task automatic check_status();
	logic [31:0] data;
	logic [31:0] exp;
	exp = {23'b0, model_flag, model_cnt};
	apb_read(addr_status, data);
	assert (data === exp)
		else abort_run($sformatf("mismatch prdata status: expected %h, got %h", exp, data));
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic test_reset_state();
	logic [31:0] data;
	check_status();
	check_reg(5'd0);
	// unmapped, below the register window
	apb_read(12'h040, data);
	assert (data === 32'h0)
		else abort_run($sformatf("mismatch unmapped prdata: expected %h, got %h", 32'h0, data));
	// register storage has no reset value, zero it through the pipeline
	for (int i = 1; i < 32; i++) begin
		issue_imm(f3_add_sub, reg_idx_t'(i), 5'd0, 12'h000, 2);
	end
	for (int i = 1; i < 32; i++) begin
		check_reg(reg_idx_t'(i));
	end
	check_status();
endtask

task automatic test_imm_ops();
	logic [31:0] v;
	logic [11:0] imm;
	// negative source, so srai differs from srli
	v     = $random(seed);
	v[31] = 1'b1;
	load_value(5'd1, v);
	imm     = rand_imm();
	imm[11] = 1'b1;
	issue_imm(f3_add_sub, 5'd3, 5'd1, imm, 2);
	issue_imm(f3_slt, 5'd4, 5'd1, rand_imm(), 2);
	issue_imm(f3_sltu, 5'd5, 5'd1, rand_imm(), 2);
	issue_imm(f3_xor, 5'd6, 5'd1, rand_imm(), 2);
	issue_imm(f3_or, 5'd7, 5'd1, rand_imm(), 2);
	issue_imm(f3_and, 5'd8, 5'd1, rand_imm(), 2);
	// random shift amount, upper bits clear
	imm       = rand_imm();
	imm[11:5] = 7'b0000000;
	issue_imm(f3_sll, 5'd9, 5'd1, imm, 2);
	issue_imm(f3_srl_sra, 5'd10, 5'd1, imm, 2);
	issue_imm(f3_srl_sra, 5'd11, 5'd1, {7'b0100000, imm[4:0]}, 2);
	for (int i = 3; i < 12; i++) begin
		check_reg(reg_idx_t'(i));
	end
endtask

task automatic test_reg_ops();
	logic [31:0] v;
	v     = $random(seed);
	v[31] = 1'b1;
	load_value(5'd12, v);
	v     = $random(seed);
	v[31] = 1'b0;
	load_value(5'd13, v);
	issue_reg(f3_add_sub, 1'b0, 5'd14, 5'd12, 5'd13, 2);
	issue_reg(f3_add_sub, 1'b1, 5'd15, 5'd12, 5'd13, 2);
	issue_reg(f3_sll, 1'b0, 5'd16, 5'd12, 5'd13, 2);
	issue_reg(f3_slt, 1'b0, 5'd17, 5'd12, 5'd13, 2);
	issue_reg(f3_sltu, 1'b0, 5'd18, 5'd12, 5'd13, 2);
	issue_reg(f3_xor, 1'b0, 5'd19, 5'd12, 5'd13, 2);
	issue_reg(f3_srl_sra, 1'b0, 5'd20, 5'd12, 5'd13, 2);
	issue_reg(f3_srl_sra, 1'b1, 5'd21, 5'd12, 5'd13, 2);
	issue_reg(f3_or, 1'b0, 5'd22, 5'd12, 5'd13, 2);
	issue_reg(f3_and, 1'b0, 5'd23, 5'd12, 5'd13, 2);
	// operands swapped, signed compare the other way
	issue_reg(f3_slt, 1'b0, 5'd24, 5'd13, 5'd12, 2);
	for (int i = 14; i < 25; i++) begin
		check_reg(reg_idx_t'(i));
	end
endtask

task automatic test_back_to_back();
	// each instruction reads the one before, no idle cycles between
	issue_imm(f3_add_sub, 5'd25, 5'd12, rand_imm(), 0);
	issue_reg(f3_add_sub, 1'b0, 5'd26, 5'd25, 5'd25, 0);
	issue_reg(f3_add_sub, 1'b1, 5'd27, 5'd26, 5'd13, 0);
	issue_imm(f3_sll, 5'd28, 5'd27, 12'd3, 0);
	issue_reg(f3_xor, 1'b0, 5'd29, 5'd28, 5'd25, 0);
	// let the last one commit
	bus_idle(2);
	for (int i = 25; i < 30; i++) begin
		check_reg(reg_idx_t'(i));
	end
endtask

task automatic test_x0_and_illegal();
	instr_u w;
	// legal writes to x0, counted but not stored
	issue_imm(f3_add_sub, 5'd0, 5'd1, rand_imm(), 2);
	issue_reg(f3_or, 1'b0, 5'd0, 5'd12, 5'd13, 2);
	// load opcode, not OP or OP-IMM
	w          = $random(seed);
	w.r.opcode = 7'b0000011;
	issue_bad(w);
	// add with a funct7 from the M extension
	w          = '0;
	w.r.funct7 = 7'b0000001;
	w.r.rs2    = 5'd2;
	w.r.rs1    = 5'd1;
	w.r.funct3 = f3_add_sub;
	w.r.rd     = 5'd5;
	w.r.opcode = opcode_op;
	issue_bad(w);
	for (int i = 0; i < 32; i++) begin
		check_reg(reg_idx_t'(i));
	end
	check_status();
endtask

`endif

// File: tests/tb_alu_core.sv
/*
 * ALU core testbench
 * clock, reset, DUT instance, watchdog and the
 * directed test sequence over the APB port
 */

`timescale 1ns/1ps

module tb_alu_core;
	import isa_pkg::*;
	import bus_map_pkg::*;

	localparam int clk_period = 20;
	// about 170 transfers in the sequence, rounded up
	localparam int num_transfers = 200;
	// 4 cycles per transfer, doubled for margin
	localparam int watchdog_ns = num_transfers * 4 * clk_period * 2;

	logic                  clock;
	logic                  rst_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic                  pready;
	logic                  pslverr;

	integer seed;

	alu_core u_dut (
		.clock   (clock),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #(clk_period / 2) clock = ~clock;

	// report, then stop at the first error
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_apb_tasks.svh"

	//////////////////////////////
	// watchdog
	//////////////////////////////

	initial begin
		#(watchdog_ns);
		$display("timeout: the test sequence did not finish in time");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////
	// sequence
	//////////////////////////////

	initial begin
		clock   = 1'b0;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		seed    = 32'h989afb86;

		// model starts from the reset state
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		model_cnt  = '0;
		model_flag = 1'b0;

		// 4 rising edges in reset, release on a falling edge
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		assert (pready === 1'b1)
			else abort_run($sformatf("mismatch pready: expected %h, got %h", 1'b1, pready));

		test_reset_state();
		test_imm_ops();
		test_reg_ops();
		test_back_to_back();
		test_x0_and_illegal();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: alu_core.f
+incdir+tests
design/isa_pkg.sv
design/bus_map_pkg.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_regfile.sv
design/alu_core.sv
tests/tb_alu_core.sv

// File: Bender.yml
package:
  name: alu_core

sources:
  # packages first, then the stages and the top level
  - design/isa_pkg.sv
  - design/bus_map_pkg.sv
  - design/instr_decode.sv
  - design/alu_execute.sv
  - design/result_regfile.sv
  - design/alu_core.sv

  # testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_alu_core.sv
